// ==== fmul_frac_pkg.sv ====
// shared widths, operand union and stage records for the fmul fraction pipeline, import with ::*
`default_nettype none

package fmul_frac_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int FRAC_W  = 53;		// significand incl. hidden bit
	localparam int PROD_W  = 106;		// full 53x53 product
	localparam int LZC_W   = 7;		// normalize shift count, 0..105
	localparam int SNG_PAD = FRAC_W - 24;	// zeros under a left-aligned single significand

	////////////////////////////////////////////////////////////////////////////
	// operand word, one 55-bit word read two ways
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [2:0]  pad;		// unused above a double fraction
		logic [51:0] frac;
	} fmul_dbl_view_t;

	typedef struct packed {
		logic [22:0] frac;		// single fraction in the top bits
		logic [31:0] pad;
	} fmul_sng_view_t;

	typedef union packed {
		fmul_dbl_view_t dbl;
		fmul_sng_view_t sng;
	} fmul_word_u;

	typedef struct packed {
		fmul_word_u word;
		logic       hid;		// hidden bit, 0 for denormal
	} fmul_op_t;

	////////////////////////////////////////////////////////////////////////////
	// stage records
	////////////////////////////////////////////////////////////////////////////

	// stage 1, aligned significands
	typedef struct packed {
		logic              valid;
		logic              dbl;
		logic [FRAC_W-1:0] sig1;
		logic [FRAC_W-1:0] sig2;
	} fmul_sig_t;

	// stage 2, raw product
	typedef struct packed {
		logic              valid;
		logic              dbl;
		logic [PROD_W-1:0] prod;
	} fmul_prod_t;

	// stage 3, normalized product
	typedef struct packed {
		logic              valid;
		logic              dbl;
		logic              zero;
		logic [LZC_W-1:0]  sh_cnt;	// leading zeros, for the exponent side
		logic [PROD_W-1:0] frac;	// bit 105 set unless zero
	} fmul_norm_t;

	// stage 4, rounded result
	typedef struct packed {
		logic              valid;
		logic [FRAC_W-2:0] frac;	// hidden bit dropped
		logic [LZC_W-1:0]  sh_cnt;
		logic              nx;		// inexact
		logic              cout;	// rounding carry out
		logic              zero;
	} fmul_res_t;

endpackage

`default_nettype wire

// ==== fmul_frac_in.sv ====
// operand input stage of the fmul fraction pipe, aligns both significands and registers on step
`timescale 1ns/1ps
`default_nettype none

module fmul_frac_in
	import fmul_frac_pkg::*;
(
	input  wire logic     i_clk,
	input  wire logic     i_rst_n,
	input  wire logic     i_step,		// level advance strobe
	input  wire logic     i_valid,
	input  wire logic     i_dbl,		// 1 = double, 0 = single
	input  wire fmul_op_t i_op1,
	input  wire fmul_op_t i_op2,
	output fmul_sig_t     o_sig
);

	////////////////////////////////////////////////////////////////////////////
	// unpack
	////////////////////////////////////////////////////////////////////////////

	// pick the view by precision, hidden bit on top, left aligned
	function automatic logic [FRAC_W-1:0] align_sig(input fmul_op_t op, input logic dbl);
		logic [FRAC_W-1:0] sig;
		if (dbl)
			sig = {op.hid, op.word.dbl.frac};
		else
			sig = {op.hid, op.word.sng.frac, {SNG_PAD{1'b0}}};	// 1+23+29
		return sig;
	endfunction

	logic [FRAC_W-1:0] sig1_d;
	logic [FRAC_W-1:0] sig2_d;

	assign sig1_d = align_sig(i_op1, i_dbl);
	assign sig2_d = align_sig(i_op2, i_dbl);

	////////////////////////////////////////////////////////////////////////////
	// stage 1 register
	////////////////////////////////////////////////////////////////////////////

	logic              valid_q;
	logic              dbl_q;
	logic [FRAC_W-1:0] sig1_q;
	logic [FRAC_W-1:0] sig2_q;

	// control bits
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			dbl_q   <= 1'b0;
		end else if (i_step) begin
			valid_q <= i_valid;
			dbl_q   <= i_dbl;
		end
	end

	// significands, held while step low
	always_ff @(posedge i_clk) begin
		if (i_step) begin
			sig1_q <= sig1_d;
			sig2_q <= sig2_d;
		end
	end

	assign o_sig = '{
		valid: valid_q,
		dbl:   dbl_q,
		sig1:  sig1_q,
		sig2:  sig2_q
	};

endmodule

`default_nettype wire

// ==== fmul_frac_core.sv ====
// two step-qualified multiply and normalize stages that the top level places before rounding
`timescale 1ns/1ps
`default_nettype none

module fmul_frac_core
	import fmul_frac_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_rst_n,
	input  wire logic      i_step,		// level advance strobe
	input  wire fmul_sig_t i_sig,		// aligned significands
	output fmul_norm_t     o_norm		// normalized product
);

	////////////////////////////////////////////////////////////////////////////
	// stage 2 multiply
	////////////////////////////////////////////////////////////////////////////

	logic [PROD_W-1:0] prod_d;

	assign prod_d = PROD_W'(i_sig.sig1) * PROD_W'(i_sig.sig2);	// full width 53x53 product

	logic              p_valid;
	logic              p_dbl;
	logic [PROD_W-1:0] p_prod;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p_valid <= 1'b0;
			p_dbl   <= 1'b0;
		end else if (i_step) begin
			p_valid <= i_sig.valid;
			p_dbl   <= i_sig.dbl;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_step)
			p_prod <= prod_d;
	end

	fmul_prod_t prod_q;			// between the two stages

	assign prod_q = '{
		valid: p_valid,
		dbl:   p_dbl,
		prod:  p_prod
	};

	////////////////////////////////////////////////////////////////////////////
	// stage 3 leading zero count and left shift
	////////////////////////////////////////////////////////////////////////////

	logic [LZC_W-1:0]  lz_cnt;
	logic              zero_d;
	logic [PROD_W-1:0] shl_d;

	// priority scan where the highest set bit wins
	// zero product leaves the count at 0
	always_comb begin
		lz_cnt = '0;
		for (int i = 0; i < PROD_W; i++) begin
			if (prod_q.prod[i])
				lz_cnt = LZC_W'(PROD_W - 1 - i);
		end
	end

	assign zero_d = ~|prod_q.prod;
	assign shl_d  = prod_q.prod << lz_cnt;	// msb lands on bit 105

	logic              n_valid;
	logic              n_dbl;
	logic              n_zero;
	logic [LZC_W-1:0]  n_cnt;
	logic [PROD_W-1:0] n_frac;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			n_valid <= 1'b0;
			n_dbl   <= 1'b0;
		end else if (i_step) begin
			n_valid <= prod_q.valid;
			n_dbl   <= prod_q.dbl;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_step) begin
			n_zero <= zero_d;
			n_cnt  <= lz_cnt;
			n_frac <= shl_d;
		end
	end

	assign o_norm = '{
		valid:  n_valid,
		dbl:    n_dbl,
		zero:   n_zero,
		sh_cnt: n_cnt,
		frac:   n_frac
	};

endmodule

`default_nettype wire

// ==== fmul_frac_rnd.sv ====
// rounding stage of the fmul fraction pipe, nearest-even at single or double, drives the result
`timescale 1ns/1ps
`default_nettype none

module fmul_frac_rnd
	import fmul_frac_pkg::*;
(
	input  wire logic       i_clk,
	input  wire logic       i_rst_n,
	input  wire logic       i_step,		// level advance strobe
	input  wire fmul_norm_t i_norm,		// normalized product
	output fmul_res_t       o_res
);

	////////////////////////////////////////////////////////////////////////////
	// kept, round and sticky
	////////////////////////////////////////////////////////////////////////////

	logic [FRAC_W-1:0] kept;		// top 53, single low part masked
	logic              lsb;
	logic              rnd_bit;
	logic              sticky;

	always_comb begin
		if (i_norm.dbl) begin
			kept    = i_norm.frac[PROD_W-1 -: FRAC_W];	// 105:53
			lsb     = i_norm.frac[53];
			rnd_bit = i_norm.frac[52];
			sticky  = |i_norm.frac[51:0];
		end else begin
			kept    = {i_norm.frac[PROD_W-1 -: 24], {SNG_PAD{1'b0}}};	// 105:82
			lsb     = i_norm.frac[82];
			rnd_bit = i_norm.frac[81];
			sticky  = |i_norm.frac[80:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// nearest-even increment
	////////////////////////////////////////////////////////////////////////////

	logic            inc;
	logic [FRAC_W:0] inc_pos;			// one extra bit for carry
	logic [FRAC_W:0] sum;

	assign inc = rnd_bit & (sticky | lsb);	// ties go to even

	always_comb begin
		if (i_norm.dbl)
			inc_pos = {{FRAC_W{1'b0}}, inc};
		else
			inc_pos = {{(FRAC_W - SNG_PAD){1'b0}}, inc, {SNG_PAD{1'b0}}};	// at bit 29
	end

	assign sum = {1'b0, kept} + inc_pos;

	fmul_res_t res_d;

	// single fraction already sits in 51:29, low bits zero
	// on carry out the kept bits wrap to all zeros
	always_comb begin
		res_d.valid  = i_norm.valid;
		res_d.frac   = sum[FRAC_W-2:0];	// hidden bit dropped
		res_d.sh_cnt = i_norm.sh_cnt;
		res_d.nx     = rnd_bit | sticky;
		res_d.cout   = sum[FRAC_W];
		res_d.zero   = i_norm.zero;
	end

	////////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_res <= '0;			// whole result clear out of reset
		else if (i_step)
			o_res <= res_d;
	end

endmodule

`default_nettype wire

// ==== fmul_frac_top.sv ====
// top of the fmul fraction pipe, four step-qualified stages from operands to rounded fraction
`timescale 1ns/1ps
`default_nettype none

module fmul_frac_top
	import fmul_frac_pkg::*;
(
	input  wire logic     i_clk,
	input  wire logic     i_rst_n,
	input  wire logic     i_step,		// advance all stages
	input  wire logic     i_valid,		// one-cycle request
	input  wire logic     i_dbl,		// precision with the request
	input  wire fmul_op_t i_op1,
	input  wire fmul_op_t i_op2,
	output fmul_res_t     o_res		// valid four steps later
);

	fmul_sig_t  sig;			// stage 1 out
	fmul_norm_t norm;			// stage 3 out

	// stage 1
	fmul_frac_in u_in (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_step  (i_step),
		.i_valid (i_valid),
		.i_dbl   (i_dbl),
		.i_op1   (i_op1),
		.i_op2   (i_op2),
		.o_sig   (sig)
	);

	// stages 2 and 3
	fmul_frac_core u_core (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_step  (i_step),
		.i_sig   (sig),
		.o_norm  (norm)
	);

	// stage 4
	fmul_frac_rnd u_rnd (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_step  (i_step),
		.i_norm  (norm),
		.o_res   (o_res)
	);

endmodule

`default_nettype wire

// ==== tb_fmul_frac.sv ====
// testbench for fmul_frac_top, runs directed and random operands against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_fmul_frac
	import fmul_frac_pkg::*;
();

	localparam int N_DIR    = 19;			// directed operations
	localparam int N_RAND   = 200;			// random operations under stalls
	localparam int STIM_LEN = N_DIR + N_RAND;
	localparam int LIMIT    = 4 * STIM_LEN + 100;	// watchdog, in clock cycles

	logic      clk;
	logic      rst_n;
	logic      step;
	logic      valid;
	logic      dbl;
	fmul_op_t  op1;
	fmul_op_t  op2;
	fmul_res_t res;

	int        seed = 44;
	int        errors = 0;
	int        cycles = 0;
	int        step_cnt = 0;			// rising edges seen with step high

	fmul_res_t exp_q[$];				// expected results, oldest first
	string     name_q[$];
	int        tag_q[$];				// step_cnt when the operation was accepted

	fmul_res_t exp_r;
	string     exp_name;
	int        exp_tag;
	fmul_res_t hold_val;
	logic      hold_chk = 1'b0;
	logic      rst_armed = 1'b0;

	fmul_frac_top uut (
		.i_clk   (clk),
		.i_rst_n (rst_n),
		.i_step  (step),
		.i_valid (valid),
		.i_dbl   (dbl),
		.i_op1   (op1),
		.i_op2   (op2),
		.o_res   (res)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;			// 40 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	// align, multiply, normalize, round to nearest-even, all in 106 bits
	function automatic fmul_res_t ref_mul(input fmul_op_t a, input fmul_op_t b, input logic dp);
		logic [105:0] s1;
		logic [105:0] s2;
		logic [105:0] n;
		logic [105:0] kept;
		logic [105:0] rbv;
		logic [105:0] carry;
		logic         rb;
		logic         st;
		int           lz;
		int           kw;
		fmul_res_t    r;
		r = '0;
		r.valid = 1'b1;
		if (dp) begin
			s1 = {53'd0, a.hid, a.word.dbl.frac};
			s2 = {53'd0, b.hid, b.word.dbl.frac};
		end else begin
			s1 = {53'd0, a.hid, a.word.sng.frac, 29'd0};	// single sits on top
			s2 = {53'd0, b.hid, b.word.sng.frac, 29'd0};
		end
		n = s1 * s2;
		if (n == '0) begin
			r.zero = 1'b1;				// everything else stays 0
			return r;
		end
		lz = 0;
		while (!n[105]) begin			// slide the msb up to bit 105
			n = n << 1;
			lz++;
		end
		kw = dp ? 53 : 24;			// kept width
		kept = n >> (106 - kw);
		rbv = n >> (105 - kw);
		rb = rbv[0];
		st = |(n << (kw + 1));			// whatever lies below the round bit
		if (rb && (st || kept[0]))
			kept = kept + 106'd1;
		carry = kept >> kw;
		r.cout = carry[0];
		r.nx = rb | st;
		r.sh_cnt = 7'(lz);
		r.frac = dp ? kept[51:0] : {kept[22:0], 29'd0};
		return r;
	endfunction

	function automatic fmul_op_t dbl_op(input logic hid, input logic [51:0] frac);
		fmul_op_t op;
		op = '0;
		op.hid = hid;
		op.word.dbl.frac = frac;
		return op;
	endfunction

	function automatic fmul_op_t sng_op(input logic hid, input logic [22:0] frac);
		fmul_op_t op;
		op = '0;
		op.hid = hid;
		op.word.sng.frac = frac;
		return op;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	// present one operation, retrying on stalled cycles until step takes it
	task automatic issue(input string name, input fmul_op_t a, input fmul_op_t b,
			input logic dp, input logic stall);
		logic go;
		go = 1'b0;
		while (!go) begin
			@(negedge clk);
			go = stall ? (($random(seed) & 3) != 0) : 1'b1;
			step  = go;
			valid = go;
			dbl   = dp;
			op1   = a;
			op2   = b;
			if (go) begin
				exp_q.push_back(ref_mul(a, b, dp));
				name_q.push_back(name);
				tag_q.push_back(step_cnt);
			end
		end
	endtask

	task automatic drain(input logic stall);
		while (exp_q.size() != 0) begin
			@(negedge clk);
			step  = stall ? (($random(seed) & 3) != 0) : 1'b1;
			valid = 1'b0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			step  = 1'b1;
			valid = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			if (rst_armed)			// first edge applies the reset
				check("reset value", 64'(0), 64'(res));
			rst_armed = 1'b1;
		end else begin
			if (hold_chk)			// previous edge was a stall
				check("stall hold", 64'(hold_val), 64'(res));
			hold_chk = !step;
			hold_val = res;
			if (step && res.valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("[ERROR] result on o_res with nothing outstanding, cycle %0d",
						cycles);
				end else begin
					exp_r    = exp_q.pop_front();
					exp_name = name_q.pop_front();
					exp_tag  = tag_q.pop_front();
					// visible after four step edges, consumed on the fifth
					check({exp_name, " latency"}, 64'(4), 64'(step_cnt - exp_tag));
					check({exp_name, " frac"}, 64'(exp_r.frac), 64'(res.frac));
					check({exp_name, " sh_cnt"}, 64'(exp_r.sh_cnt), 64'(res.sh_cnt));
					check({exp_name, " nx"}, 64'(exp_r.nx), 64'(res.nx));
					check({exp_name, " cout"}, 64'(exp_r.cout), 64'(res.cout));
					check({exp_name, " zero"}, 64'(exp_r.zero), 64'(res.zero));
				end
			end
			if (step)
				step_cnt++;
		end
	end

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("[ERROR] timeout after %0d cycles, %0d results never arrived",
			cycles, exp_q.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [63:0] r64;
		fmul_op_t    a;
		fmul_op_t    b;
		logic        dp;
		int          i;
		rst_n = 1'b0;
		step  = 1'b1;				// data regs load known values in reset
		valid = 1'b0;
		dbl   = 1'b0;
		op1   = '0;
		op2   = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// lone op into an empty pipe, step held high
		issue("latency", dbl_op(1'b1, 52'h8000000000000), dbl_op(1'b1, 52'h0), 1'b1, 1'b0);
		drain(1'b0);

		// double normals
		issue("dbl 1.0x1.0", dbl_op(1'b1, 52'h0), dbl_op(1'b1, 52'h0), 1'b1, 1'b0);
		issue("dbl ones", dbl_op(1'b1, 52'hFFFFFFFFFFFFF), dbl_op(1'b1, 52'hFFFFFFFFFFFFF),
			1'b1, 1'b0);
		issue("dbl carry", dbl_op(1'b1, 52'h1), dbl_op(1'b1, 52'hFFFFFFFFFFFFE), 1'b1, 1'b0);
		issue("dbl 1.5x1.25", dbl_op(1'b1, 52'h8000000000000), dbl_op(1'b1, 52'h4000000000000),
			1'b1, 1'b0);
		drain(1'b0);

		// singles, fraction in 51:29
		issue("sng 1.5x1.5", sng_op(1'b1, 23'h400000), sng_op(1'b1, 23'h400000), 1'b0, 1'b0);
		issue("sng 1.0x1.0", sng_op(1'b1, 23'h0), sng_op(1'b1, 23'h0), 1'b0, 1'b0);
		issue("sng carry", sng_op(1'b1, 23'h000001), sng_op(1'b1, 23'h7FFFFE), 1'b0, 1'b0);
		issue("sng ones", sng_op(1'b1, 23'h7FFFFF), sng_op(1'b1, 23'h7FFFFF), 1'b0, 1'b0);
		drain(1'b0);

		// denormals and zeros
		issue("dbl denorm x 1.0", dbl_op(1'b0, 52'h1), dbl_op(1'b1, 52'h0), 1'b1, 1'b0);
		issue("dbl denorm x denorm", dbl_op(1'b0, 52'h3), dbl_op(1'b0, 52'h5), 1'b1, 1'b0);
		issue("dbl zero", dbl_op(1'b0, 52'h0), dbl_op(1'b1, 52'h123), 1'b1, 1'b0);
		issue("sng denorm", sng_op(1'b0, 23'h000001), sng_op(1'b1, 23'h0), 1'b0, 1'b0);
		issue("sng zero", sng_op(1'b0, 23'h0), sng_op(1'b0, 23'h0), 1'b0, 1'b0);
		drain(1'b0);

		// exact halfway products, 2^53+1 = 3 * 0xAAAAAAAAAAAAB and friends
		issue("dbl tie even", dbl_op(1'b0, 52'h3), dbl_op(1'b0, 52'hAAAAAAAAAAAAB), 1'b1, 1'b0);
		issue("dbl tie odd", dbl_op(1'b0, 52'h5), dbl_op(1'b0, 52'h6666666666667), 1'b1, 1'b0);
		issue("dbl tie normal", dbl_op(1'b1, 52'h1), dbl_op(1'b1, 52'h8000000000000),
			1'b1, 1'b0);
		issue("sng tie even", sng_op(1'b0, 23'h61), sng_op(1'b0, 23'h2A3A1), 1'b0, 1'b0);
		issue("sng tie odd", sng_op(1'b0, 23'h3), sng_op(1'b0, 23'h555559), 1'b0, 1'b0);
		drain(1'b0);

		// random operands, step dropped on about a quarter of the cycles
		for (i = 0; i < N_RAND; i++) begin
			r64 = {$random(seed), $random(seed)};
			a.word = r64[54:0];			// pad bits random too
			a.hid = ($random(seed) & 7) != 0;	// mostly normal
			r64 = {$random(seed), $random(seed)};
			b.word = r64[54:0];
			b.hid = ($random(seed) & 7) != 0;
			dp = ($random(seed) & 1) != 0;
			issue($sformatf("random %0d", i), a, b, dp, 1'b1);
		end
		drain(1'b1);
		idle(8);				// catch stray outputs

		$display("[DONE] %0d errors, %0d results outstanding", errors, exp_q.size());
		if (errors == 0 && exp_q.size() == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
fmul_frac_pkg.sv
fmul_frac_in.sv
fmul_frac_core.sv
fmul_frac_rnd.sv
fmul_frac_top.sv
tb_fmul_frac.sv

// ==== Makefile ====
# Verilator build and run of the fmul fraction pipeline testbench

SRCS := $(shell cat all.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_fmul_frac: all.f $(SRCS)
	verilator --binary --top-module tb_fmul_frac -f all.f -o Vtb_fmul_frac

run: obj_dir/Vtb_fmul_frac
	./obj_dir/Vtb_fmul_frac | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
